// ==== common/sink_defines.svh ====
`ifndef SINK_DEFINES_SVH
`define SINK_DEFINES_SVH

// Width of one data beat in bits; a beat is SINK_DATA_W/8 bytes
`define SINK_DATA_W 64

// Byte address width of the AW channel
`define SINK_ADDR_W 32

// Buffer depth in beats and the index width that covers it
`define SINK_DEPTH 256
`define SINK_INDEX_W 8

// Byte address that maps onto buffer index 0
`define SINK_BASE_ADDR 32'h0000_1000

// Cycles from the AW handshake edge until w_ready is high
`define SINK_AW_TO_WREADY 2

// Cycles from the edge that takes the last beat until b_valid is high
`define SINK_B_LATENCY 3

// Width of the shared latency timer
`define SINK_TIMER_W 8

`endif

// ==== common/axi_pkg.sv ====
`include "sink_defines.svh"

package axi_pkg;

    // Write address word, one per burst
    typedef struct packed {
        logic [`SINK_ADDR_W-1:0] addr;
        // Number of beats minus one
        logic [7:0]              len;
    } aw_req_t;

    // Write data word
    typedef struct packed {
        logic [`SINK_DATA_W-1:0] data;
        logic                    last;
    } w_beat_t;

    // Write response codes; EXOKAY and DECERR are never returned by the sink
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2
    } resp_t;

endpackage

// ==== common/sink_pkg.sv ====
`include "sink_defines.svh"

package sink_pkg;

    // Phases of one write burst, in the order they are visited
    typedef enum logic [1:0] {
        S_IDLE      = 2'd0,
        S_ADDR_WAIT = 2'd1,
        S_DATA      = 2'd2,
        S_RESP      = 2'd3
    } sink_state_t;

    // One write into the beat buffer
    typedef struct packed {
        logic [`SINK_INDEX_W-1:0] index;
        logic [`SINK_DATA_W-1:0]  data;
    } mem_write_t;

endpackage

// ==== rtl/latency_timer.sv ====
`include "sink_defines.svh"

module latency_timer (
    input  logic                     clock,
    input  logic                     arst_n,
    input  logic                     start,
    input  logic [`SINK_TIMER_W-1:0] length,
    output logic                     done
);

    logic [`SINK_TIMER_W-1:0] count;

    // The cycle of the start pulse counts as the first cycle of the wait.
    // So done is high in the cycle whose closing edge completes length cycles,
    // and a consumer that acts on done at that edge lands exactly on time
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (start) begin
            if (length == '0) begin
                count <= '0;
            end else begin
                count <= length - 1'b1;
            end
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // Stays high at zero until the next start reloads the count
    assign done = (count == '0);

endmodule

// ==== rtl/write_sink_fsm.sv ====
`include "sink_defines.svh"

module write_sink_fsm (
    input  logic                     clock,
    input  logic                     arst_n,
    input  logic                     aw_valid,
    input  axi_pkg::aw_req_t         aw,
    input  logic                     w_valid,
    input  logic                     b_ready,
    input  logic                     timer_done,
    input  logic                     at_last_beat,
    input  logic                     burst_error,
    output logic                     aw_ready,
    output logic                     w_ready,
    output logic                     b_valid,
    output axi_pkg::resp_t           b_resp,
    output logic                     timer_start,
    output logic [`SINK_TIMER_W-1:0] timer_length,
    output logic                     burst_start,
    output logic                     beat_fire
);

    import axi_pkg::*;
    import sink_pkg::*;

    localparam logic [`SINK_TIMER_W-1:0] ADDR_WAIT = `SINK_AW_TO_WREADY;
    localparam logic [`SINK_TIMER_W-1:0] RESP_WAIT = `SINK_B_LATENCY;

    sink_state_t state;
    logic        aw_fire;
    logic        last_fire;

    // Both ready signals follow the state register directly
    assign aw_ready = (state == S_IDLE);
    assign w_ready  = (state == S_DATA);

    assign aw_fire   = aw_valid && aw_ready;
    assign beat_fire = w_valid && w_ready;

    // The fire on beat number len closes the data phase
    assign last_fire = beat_fire && at_last_beat;

    assign burst_start = aw_fire;

    // One timer serves both waits, as the two phases never overlap
    assign timer_start  = aw_fire || last_fire;
    assign timer_length = aw_fire ? ADDR_WAIT : RESP_WAIT;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state   <= S_IDLE;
            b_valid <= 1'b0;
            b_resp  <= RESP_OKAY;
        end else begin
            case (state)
                S_IDLE: begin
                    if (aw_fire) begin
                        state <= S_ADDR_WAIT;
                    end
                end
                S_ADDR_WAIT: begin
                    if (timer_done) begin
                        state <= S_DATA;
                    end
                end
                S_DATA: begin
                    // w_ready drops on the edge that takes the last beat
                    if (last_fire) begin
                        state <= S_RESP;
                    end
                end
                S_RESP: begin
                    if (!b_valid) begin
                        if (timer_done) begin
                            b_valid <= 1'b1;
                            b_resp  <= burst_error ? RESP_SLVERR : RESP_OKAY;
                        end
                    end else if (b_ready) begin
                        // Response and its code are held until the master takes them
                        b_valid <= 1'b0;
                        state   <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== rtl/burst_address_gen.sv ====
`include "sink_defines.svh"

module burst_address_gen (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 burst_start,
    input  axi_pkg::aw_req_t     aw,
    input  logic                 beat_fire,
    input  axi_pkg::w_beat_t     w,
    output logic                 at_last_beat,
    output logic                 burst_error,
    output sink_pkg::mem_write_t mem_wr,
    output logic                 mem_wr_en
);

    // Beats are DATA_W/8 bytes wide, so the byte offset drops this many bits
    localparam int BEAT_SHIFT = $clog2(`SINK_DATA_W / 8);

    logic [`SINK_ADDR_W-1:0] offset;
    logic [`SINK_ADDR_W-1:0] index_q;
    logic                    below_base_q;
    logic [7:0]              beat_q;
    logic [7:0]              len_q;
    logic                    in_range;
    logic                    last_mismatch;

    assign offset = aw.addr - `SINK_BASE_ADDR;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            index_q      <= '0;
            below_base_q <= 1'b0;
            beat_q       <= '0;
            len_q        <= '0;
            burst_error  <= 1'b0;
        end else if (burst_start) begin
            index_q      <= offset >> BEAT_SHIFT;
            below_base_q <= (aw.addr < `SINK_BASE_ADDR);
            beat_q       <= '0;
            len_q        <= aw.len;
            burst_error  <= 1'b0;
        end else if (beat_fire) begin
            index_q <= index_q + 1'b1;
            beat_q  <= beat_q + 1'b1;
            // The error is sticky for the rest of the burst
            if (!in_range || last_mismatch) begin
                burst_error <= 1'b1;
            end
        end
    end

    assign in_range      = !below_base_q && (index_q < `SINK_DEPTH);
    assign at_last_beat  = (beat_q == len_q);
    assign last_mismatch = (w.last != at_last_beat);

    // Out-of-range beats are still accepted on the bus but never reach the buffer
    assign mem_wr.index = index_q[`SINK_INDEX_W-1:0];
    assign mem_wr.data  = w.data;
    assign mem_wr_en    = beat_fire && in_range;

endmodule

// ==== rtl/sink_memory.sv ====
`include "sink_defines.svh"

module sink_memory (
    input  logic                     clock,
    input  logic                     arst_n,
    input  sink_pkg::mem_write_t     mem_wr,
    input  logic                     mem_wr_en,
    input  logic                     beat_fire,
    input  logic [`SINK_INDEX_W-1:0] peek_index,
    output logic [`SINK_DATA_W-1:0]  peek_data,
    output logic [`SINK_INDEX_W-1:0] beat_count
);

    logic [`SINK_DATA_W-1:0] buffer [`SINK_DEPTH];

    always_ff @(posedge clock) begin
        if (mem_wr_en) begin
            buffer[mem_wr.index] <= mem_wr.data;
        end
    end

    // Read-back port for checking the buffer, no latency
    assign peek_data = buffer[peek_index];

    // Counts every accepted beat, in range or not
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            beat_count <= '0;
        end else if (beat_fire) begin
            if (beat_count == `SINK_INDEX_W'(`SINK_DEPTH - 1)) begin
                beat_count <= '0;
            end else begin
                beat_count <= beat_count + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/axi_write_sink.sv ====
`include "sink_defines.svh"

module axi_write_sink (
    input  logic                     clock,
    input  logic                     arst_n,
    // AW channel
    input  logic                     aw_valid,
    output logic                     aw_ready,
    input  axi_pkg::aw_req_t         aw,
    // W channel
    input  logic                     w_valid,
    output logic                     w_ready,
    input  axi_pkg::w_beat_t         w,
    // B channel
    output logic                     b_valid,
    input  logic                     b_ready,
    output axi_pkg::resp_t           b_resp,
    // Buffer read-back and beat counter
    input  logic [`SINK_INDEX_W-1:0] peek_index,
    output logic [`SINK_DATA_W-1:0]  peek_data,
    output logic [`SINK_INDEX_W-1:0] beat_count
);

    import sink_pkg::*;

    logic                     timer_start;
    logic [`SINK_TIMER_W-1:0] timer_length;
    logic                     timer_done;
    logic                     burst_start;
    logic                     beat_fire;
    logic                     at_last_beat;
    logic                     burst_error;
    mem_write_t               mem_wr;
    logic                     mem_wr_en;

    write_sink_fsm u_fsm (
        .clock        (clock),
        .arst_n       (arst_n),
        .aw_valid     (aw_valid),
        .aw           (aw),
        .w_valid      (w_valid),
        .b_ready      (b_ready),
        .timer_done   (timer_done),
        .at_last_beat (at_last_beat),
        .burst_error  (burst_error),
        .aw_ready     (aw_ready),
        .w_ready      (w_ready),
        .b_valid      (b_valid),
        .b_resp       (b_resp),
        .timer_start  (timer_start),
        .timer_length (timer_length),
        .burst_start  (burst_start),
        .beat_fire    (beat_fire)
    );

    latency_timer u_timer (
        .clock  (clock),
        .arst_n (arst_n),
        .start  (timer_start),
        .length (timer_length),
        .done   (timer_done)
    );

    burst_address_gen u_addr_gen (
        .clock        (clock),
        .arst_n       (arst_n),
        .burst_start  (burst_start),
        .aw           (aw),
        .beat_fire    (beat_fire),
        .w            (w),
        .at_last_beat (at_last_beat),
        .burst_error  (burst_error),
        .mem_wr       (mem_wr),
        .mem_wr_en    (mem_wr_en)
    );

    sink_memory u_memory (
        .clock      (clock),
        .arst_n     (arst_n),
        .mem_wr     (mem_wr),
        .mem_wr_en  (mem_wr_en),
        .beat_fire  (beat_fire),
        .peek_index (peek_index),
        .peek_data  (peek_data),
        .beat_count (beat_count)
    );

endmodule

// ==== testbench/axi_write_sink_assertions.sv ====
`include "sink_defines.svh"

module axi_write_sink_assertions (
    input logic                  clock,
    input logic                  arst_n,
    input logic                  aw_valid,
    input logic                  aw_ready,
    input logic                  w_ready,
    input logic                  b_valid,
    input logic                  b_ready,
    input axi_pkg::resp_t        b_resp,
    input sink_pkg::sink_state_t state
);

    import sink_pkg::*;

    // Only one burst is in flight, so AW opens again only after the B handshake
    aw_ready_after_b: assert property (@(posedge clock) disable iff (!arst_n)
        $rose(aw_ready) |-> $past(state == S_RESP && b_valid && b_ready))
        else $error("aw_ready rose without a completed write response");

    b_held_until_ready: assert property (@(posedge clock) disable iff (!arst_n)
        (b_valid && !b_ready) |=> (b_valid && $stable(b_resp)))
        else $error("The write response changed before b_ready");

    // The handshake is sampled one edge before the state register moves
    w_ready_latency: assert property (@(posedge clock) disable iff (!arst_n)
        (aw_valid && aw_ready) |-> ##(`SINK_AW_TO_WREADY + 1) $rose(w_ready))
        else $error("w_ready did not rise on time after the AW handshake");

    b_valid_latency: assert property (@(posedge clock) disable iff (!arst_n)
        $fell(w_ready) |-> ##(`SINK_B_LATENCY) $rose(b_valid))
        else $error("b_valid did not rise on time after the last beat");

endmodule

bind axi_write_sink axi_write_sink_assertions u_assertions (
    .clock    (clock),
    .arst_n   (arst_n),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w_ready  (w_ready),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .b_resp   (b_resp),
    .state    (u_fsm.state)
);

// ==== testbench/axi_write_sink_tb.sv ====
`include "sink_defines.svh"

module axi_write_sink_tb;

    import axi_pkg::*;

    localparam int NUM_ROWS     = 12;
    localparam int RESET_CYCLES = 3;
    localparam int BEAT_BYTES   = `SINK_DATA_W / 8;
    // Address wait, response latency, handshakes and the peek sweep of one row
    localparam int ROW_OVERHEAD = `SINK_AW_TO_WREADY + `SINK_B_LATENCY + `SINK_DEPTH + 8;

    logic                     clock;
    logic                     arst_n;
    logic                     aw_valid;
    logic                     aw_ready;
    aw_req_t                  aw;
    logic                     w_valid;
    logic                     w_ready;
    w_beat_t                  w;
    logic                     b_valid;
    logic                     b_ready;
    resp_t                    b_resp;
    logic [`SINK_INDEX_W-1:0] peek_index;
    logic [`SINK_DATA_W-1:0]  peek_data;
    logic [`SINK_INDEX_W-1:0] beat_count;

    // Stimulus table with one burst per row
    string                    row_name    [NUM_ROWS];
    logic [`SINK_ADDR_W-1:0]  row_addr    [NUM_ROWS];
    logic [7:0]               row_len     [NUM_ROWS];
    logic [7:0]               row_gaps    [NUM_ROWS];
    int                       row_bdelay  [NUM_ROWS];
    logic                     row_badlast [NUM_ROWS];
    resp_t                    row_resp    [NUM_ROWS];
    int                       row_count;

    // Reference model of the buffer and of the accepted beats
    logic [`SINK_DATA_W-1:0]  model_mem     [`SINK_DEPTH];
    logic                     model_written [`SINK_DEPTH];
    int                       model_count;

    int                       cycle_count;
    int                       cycle_limit;

    axi_write_sink DUT (
        .clock      (clock),
        .arst_n     (arst_n),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .aw         (aw),
        .w_valid    (w_valid),
        .w_ready    (w_ready),
        .w          (w),
        .b_valid    (b_valid),
        .b_ready    (b_ready),
        .b_resp     (b_resp),
        .peek_index (peek_index),
        .peek_data  (peek_data),
        .beat_count (beat_count)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the bursts did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $fatal(1, "Simulation stopped by the watchdog");
        end
    end

    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic add_row(input string name, input logic [`SINK_ADDR_W-1:0] addr,
                           input logic [7:0] len, input logic [7:0] gaps, input int bdelay,
                           input logic badlast, input resp_t resp);
        row_name[row_count]    = name;
        row_addr[row_count]    = addr;
        row_len[row_count]     = len;
        row_gaps[row_count]    = gaps;
        row_bdelay[row_count]  = bdelay;
        row_badlast[row_count] = badlast;
        row_resp[row_count]    = resp;
        row_count++;
    endtask

    task automatic check_resp(input string name, input resp_t expected, input resp_t actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Response mismatch");
        end
    endtask

    task automatic check_data(input string name, input logic [`SINK_DATA_W-1:0] expected,
                              input logic [`SINK_DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Buffer data mismatch");
        end
    endtask

    task automatic check_count(input string name, input logic [`SINK_INDEX_W-1:0] expected,
                               input logic [`SINK_INDEX_W-1:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Beat count mismatch");
        end
    endtask

    task automatic check_level(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Handshake level mismatch");
        end
    endtask

    function automatic int gap_total(input logic [7:0] pattern, input logic [7:0] len);
        int total;
        total = 0;
        for (int k = 0; k <= int'(len); k++) begin
            if (pattern[k % 8]) begin
                total++;
            end
        end
        return total;
    endfunction

    task automatic run_burst(input int r);
        logic [`SINK_DATA_W-1:0] data;
        logic                    ready_seen;
        logic                    gap_pending;
        logic                    below_base;
        int                      first_index;
        int                      index;
        int                      beat;
        int                      len;

        len         = int'(row_len[r]);
        below_base  = (row_addr[r] < `SINK_BASE_ADDR);
        first_index = below_base ? 0 : int'((row_addr[r] - `SINK_BASE_ADDR) / BEAT_BYTES);

        aw_valid = 1'b1;
        aw.addr  = row_addr[r];
        aw.len   = row_len[r];
        do begin
            ready_seen = aw_ready;
            next_cycle();
        end while (!ready_seen);
        aw_valid = 1'b0;

        // A set bit in the gap pattern idles w_valid for one cycle before that beat
        beat        = 0;
        gap_pending = row_gaps[r][0];
        data        = {$urandom, $urandom};
        while (beat <= len) begin
            ready_seen = w_ready;
            if (ready_seen && gap_pending) begin
                w_valid     = 1'b0;
                gap_pending = 1'b0;
                next_cycle();
            end else begin
                w_valid = 1'b1;
                w.data  = data;
                w.last  = row_badlast[r] ? (beat + 1 == len) : (beat == len);
                next_cycle();
                if (ready_seen) begin
                    index = first_index + beat;
                    if (!below_base && index < `SINK_DEPTH) begin
                        model_mem[index]     = data;
                        model_written[index] = 1'b1;
                    end
                    model_count++;
                    beat++;
                    gap_pending = row_gaps[r][beat % 8];
                    data        = {$urandom, $urandom};
                end
            end
        end
        w_valid = 1'b0;
        w.last  = 1'b0;

        while (!b_valid) begin
            next_cycle();
        end
        check_resp(row_name[r], row_resp[r], b_resp);
        repeat (row_bdelay[r]) begin
            check_level({row_name[r], " aw_ready held low"}, 1'b0, aw_ready);
            check_level({row_name[r], " b_valid held"}, 1'b1, b_valid);
            check_resp({row_name[r], " b_resp held"}, row_resp[r], b_resp);
            next_cycle();
        end
        b_ready = 1'b1;
        next_cycle();
        b_ready = 1'b0;
        check_level({row_name[r], " b_valid cleared"}, 1'b0, b_valid);
        check_level({row_name[r], " aw_ready restored"}, 1'b1, aw_ready);
    endtask

    task automatic sweep_buffer(input int r);
        for (int i = 0; i < `SINK_DEPTH; i++) begin
            peek_index = `SINK_INDEX_W'(i);
            #1;
            if (model_written[i]) begin
                check_data($sformatf("%s peek %0d", row_name[r], i), model_mem[i], peek_data);
            end
            next_cycle();
        end
        check_count({row_name[r], " beat_count"},
                    `SINK_INDEX_W'(model_count % `SINK_DEPTH), beat_count);
    endtask

    initial begin
        arst_n      = 1'b0;
        aw_valid    = 1'b0;
        aw          = '0;
        w_valid     = 1'b0;
        w           = '0;
        b_ready     = 1'b0;
        peek_index  = '0;
        cycle_count = 0;
        row_count   = 0;
        model_count = 0;
        void'($urandom(32'h62be81a0));

        add_row("single_beat_base",   32'h0000_1000, 8'd0,   8'h00, 0, 1'b0, RESP_OKAY);
        add_row("single_beat_mid",    32'h0000_1080, 8'd0,   8'h00, 0, 1'b0, RESP_OKAY);
        add_row("full_buffer",        32'h0000_1000, 8'd255, 8'h00, 0, 1'b0, RESP_OKAY);
        add_row("burst_gaps",         32'h0000_1100, 8'd7,   8'hA6, 0, 1'b0, RESP_OKAY);
        add_row("b_backpressure",     32'h0000_1200, 8'd3,   8'h02, 5, 1'b0, RESP_OKAY);
        add_row("after_backpressure", 32'h0000_1300, 8'd1,   8'h00, 0, 1'b0, RESP_OKAY);
        add_row("past_end",           32'h0000_17E0, 8'd7,   8'h10, 0, 1'b0, RESP_SLVERR);
        add_row("start_out_of_range", 32'h0000_1800, 8'd3,   8'h00, 1, 1'b0, RESP_SLVERR);
        add_row("below_base",         32'h0000_0FF0, 8'd1,   8'h00, 0, 1'b0, RESP_SLVERR);
        add_row("wrong_wlast_early",  32'h0000_1400, 8'd3,   8'h04, 0, 1'b1, RESP_SLVERR);
        add_row("wrong_wlast_single", 32'h0000_1500, 8'd0,   8'h00, 2, 1'b1, RESP_SLVERR);
        add_row("final_wrap",         32'h0000_1600, 8'd63,  8'h49, 0, 1'b0, RESP_OKAY);

        cycle_limit = RESET_CYCLES + 50;
        for (int r = 0; r < row_count; r++) begin
            cycle_limit += int'(row_len[r]) + 1 + gap_total(row_gaps[r], row_len[r])
                           + row_bdelay[r] + ROW_OVERHEAD;
        end
        for (int i = 0; i < `SINK_DEPTH; i++) begin
            model_written[i] = 1'b0;
        end

        repeat (RESET_CYCLES) @(posedge clock);
        #2;
        arst_n = 1'b1;
        check_level("reset aw_ready", 1'b1, aw_ready);
        check_level("reset w_ready", 1'b0, w_ready);
        check_level("reset b_valid", 1'b0, b_valid);

        for (int r = 0; r < row_count; r++) begin
            run_burst(r);
            sweep_buffer(r);
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+common
common/axi_pkg.sv
common/sink_pkg.sv
rtl/latency_timer.sv
rtl/write_sink_fsm.sv
rtl/burst_address_gen.sv
rtl/sink_memory.sv
rtl/axi_write_sink.sv
testbench/axi_write_sink_assertions.sv
testbench/axi_write_sink_tb.sv

// ==== run_sim.sh ====
#!/bin/sh

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module axi_write_sink_tb -Mdir obj_dir -o axi_write_sink_sim > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/axi_write_sink_sim > sim.log 2>&1
cat sim.log

grep -q "TEST FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
